// File: piso_pkg.sv
package piso_pkg;

    // =========================================================
    // Sizing
    // =========================================================
    parameter int DATA_W_DEF = 64;          // Wide side and chunk bus width

    // Width field must hold the value DATA_W itself
    function automatic int clog2_plus1(input int val);
        return $clog2(val) + 1;
    endfunction

    // =========================================================
    // Register map
    // =========================================================
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,                  // Enable and soft clear
        REG_BW     = 2'd1,                  // Input and output widths
        REG_STATUS = 2'd2,                  // Serializer busy
        REG_PKTS   = 2'd3                   // Finished packet count
    } reg_addr_e;

    parameter int CTRL_EN_BIT     = 0;
    parameter int CTRL_CLR_BIT    = 1;      // Self-clearing
    parameter int BW_OUT_LSB      = 16;     // Output width in upper half
    parameter int STATUS_BUSY_BIT = 0;

    // =========================================================
    // Bus slave states
    // =========================================================
    typedef enum logic {
        WB_IDLE = 1'b0,                     // Waiting for cyc and stb
        WB_ACK  = 1'b1                      // Single ack cycle
    } wb_state_e;

endpackage

// File: wb_cfg_regs.sv
`timescale 1ns/1ps

module wb_cfg_regs #(
    parameter int  DATA_W = piso_pkg::DATA_W_DEF,
    localparam int BW_W   = piso_pkg::clog2_plus1(DATA_W)
) (
    input  logic            CLK,
    input  logic            RST_N,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_we,
    input  logic [1:0]      wb_adr,
    input  logic [31:0]     wb_dat_w,
    output logic [31:0]     wb_dat_r,
    output logic            wb_ack,
    input  logic            busy,
    input  logic            out_vld,
    input  logic            out_rdy,
    input  logic            out_last,
    output logic [BW_W-1:0] inp_bw,
    output logic [BW_W-1:0] out_bw,
    output logic            enable,
    output logic            soft_clr
);
    import piso_pkg::*;

    wb_state_e   state;
    reg_addr_e   adr;
    logic        req;                       // New access seen in idle
    logic        wr;
    logic [31:0] pkt_cnt;                   // Last chunks leaving the output slice

    assign adr    = reg_addr_e'(wb_adr);
    assign req    = wb_cyc & wb_stb & (state == WB_IDLE);
    assign wr     = req & wb_we;
    assign wb_ack = (state == WB_ACK);      // Exactly one cycle per access

    // =========================================================
    // Bus handshake
    // =========================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state <= WB_IDLE;
        end else if (state == WB_ACK) begin
            state <= WB_IDLE;               // Master drops stb after ack
        end else if (req) begin
            state <= WB_ACK;
        end
    end

    // Write lands on the idle edge so it is visible during ack
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            enable   <= 1'b0;
            soft_clr <= 1'b0;
            inp_bw   <= BW_W'(DATA_W);
            out_bw   <= BW_W'(DATA_W);
        end else begin
            soft_clr <= wr && (adr == REG_CTRL) && wb_dat_w[CTRL_CLR_BIT];  // Pulse
            if (wr && (adr == REG_CTRL))
                enable <= wb_dat_w[CTRL_EN_BIT];
            if (wr && (adr == REG_BW)) begin
                inp_bw <= wb_dat_w[BW_W-1:0];
                out_bw <= wb_dat_w[BW_OUT_LSB +: BW_W];
            end
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N)
            pkt_cnt <= '0;
        else if (out_vld && out_rdy && out_last)
            pkt_cnt <= pkt_cnt + 32'd1;     // One per finished packet
    end

    // Read mux, sampled by master in the ack cycle
    always_comb begin
        wb_dat_r = '0;
        case (adr)
            REG_CTRL:   wb_dat_r[CTRL_EN_BIT] = enable;     // Clear bit reads 0
            REG_BW: begin
                wb_dat_r[BW_W-1:0]            = inp_bw;
                wb_dat_r[BW_OUT_LSB +: BW_W]  = out_bw;
            end
            REG_STATUS: wb_dat_r[STATUS_BUSY_BIT] = busy;
            REG_PKTS:   wb_dat_r = pkt_cnt;
            default:    wb_dat_r = '0;
        endcase
    end

    // Serializer needs a nonzero divisor of the input width
    a_bw_legal: assert property (@(posedge CLK) disable iff (!RST_N)
        enable |-> (out_bw != '0) && (out_bw <= inp_bw) && (inp_bw % out_bw == '0))
        else $error("bad width pair inp %0d out %0d", inp_bw, out_bw);

endmodule

// File: stream_in_slice.sv
`timescale 1ns/1ps

module stream_in_slice #(
    parameter int DATA_W = piso_pkg::DATA_W_DEF
) (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              clr,
    input  logic              enable,
    input  logic [DATA_W-1:0] in_dat,
    input  logic              in_vld,
    input  logic              in_last,
    output logic              in_rdy,
    output logic [DATA_W-1:0] s_dat,
    output logic              s_vld,
    output logic              s_last,
    input  logic              s_rdy
);

    logic              skd_vld;             // Skid entry occupied
    logic [DATA_W-1:0] skd_dat;
    logic              skd_last;
    logic              acc;                 // Upstream handshake
    logic              main_ld;             // Main entry free or draining

    assign in_rdy  = enable & ~skd_vld;     // Registered term only plus enable
    assign acc     = in_vld & in_rdy;
    assign main_ld = ~s_vld | s_rdy;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            s_vld   <= 1'b0;
            skd_vld <= 1'b0;
        end else if (clr) begin
            s_vld   <= 1'b0;                // Soft clear empties both entries
            skd_vld <= 1'b0;
        end else if (main_ld) begin
            s_vld   <= skd_vld | acc;       // Skid first, it is older
            skd_vld <= 1'b0;
        end else if (acc) begin
            skd_vld <= 1'b1;                // Stalled, park one beat
        end
    end

    always_ff @(posedge CLK) begin
        if (main_ld) begin
            s_dat  <= skd_vld ? skd_dat  : in_dat;
            s_last <= skd_vld ? skd_last : in_last;
        end
        if (!main_ld && acc) begin
            skd_dat  <= in_dat;
            skd_last <= in_last;
        end
    end

    // Upstream keeps a refused beat steady until it is taken
    a_hold_stable: assert property (@(posedge CLK) disable iff (!RST_N)
        (in_vld && !in_rdy) |=> (in_vld && $stable(in_dat) && $stable(in_last)));

endmodule

// File: piso_flex.sv
`timescale 1ns/1ps

module piso_flex #(
    parameter int  DATA_W = piso_pkg::DATA_W_DEF,
    localparam int BW_W   = piso_pkg::clog2_plus1(DATA_W)
) (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              clr,
    input  logic [BW_W-1:0]   inp_bw,
    input  logic [BW_W-1:0]   out_bw,
    input  logic [DATA_W-1:0] in_dat,
    input  logic              in_vld,
    input  logic              in_last,
    output logic              in_rdy,
    output logic [DATA_W-1:0] out_dat,
    output logic              out_vld,
    output logic              out_last,
    input  logic              out_rdy,
    output logic              busy
);

    logic [BW_W-1:0]   count;               // Counts down, 0 means first chunk
    logic [BW_W-1:0]   num_shifts;          // Chunks per word
    logic [BW_W-1:0]   idx;                 // Chunk index in word
    logic [2*BW_W-1:0] shamt;
    logic              last_chunk;
    logic [DATA_W:0]   inp_mask_w;          // One spare bit for full width
    logic [DATA_W:0]   out_mask_w;
    logic [DATA_W-1:0] inp_mask;
    logic [DATA_W-1:0] out_mask;
    logic [DATA_W-1:0] shifted;

    // =========================================================
    // Chunk select
    // =========================================================
    assign num_shifts = inp_bw / out_bw;
    assign last_chunk = (count == BW_W'(1)) | (num_shifts == BW_W'(1));  // Ratio one
    assign idx        = (count == '0) ? '0 : num_shifts - count;
    assign shamt      = idx * out_bw;

    assign inp_mask_w = ((DATA_W+1)'(1) << inp_bw) - 1'b1;
    assign out_mask_w = ((DATA_W+1)'(1) << out_bw) - 1'b1;
    assign inp_mask   = inp_mask_w[DATA_W-1:0];
    assign out_mask   = out_mask_w[DATA_W-1:0];

    // Low bits first, nothing above the output width
    assign shifted = (in_dat & inp_mask) >> shamt;
    assign out_dat = shifted & out_mask;

    // =========================================================
    // Handshake
    // =========================================================
    assign out_vld  = in_vld;
    assign out_last = in_last & last_chunk;
    assign in_rdy   = in_vld & out_rdy & last_chunk;   // Word retires with final chunk
    assign busy     = in_vld | (count != '0);

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            count <= '0;
        end else if (clr) begin
            count <= '0;
        end else if (out_vld && out_rdy) begin
            if (last_chunk)
                count <= '0;                // Next word starts fresh
            else if (count == '0)
                count <= num_shifts - 1'b1;
            else
                count <= count - 1'b1;
        end
    end

endmodule

// File: stream_out_slice.sv
`timescale 1ns/1ps

module stream_out_slice #(
    parameter int DATA_W = piso_pkg::DATA_W_DEF
) (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              clr,
    input  logic [DATA_W-1:0] s_dat,
    input  logic              s_vld,
    input  logic              s_last,
    output logic              s_rdy,
    output logic [DATA_W-1:0] out_dat,
    output logic              out_vld,
    output logic              out_last,
    input  logic              out_rdy
);

    logic [DATA_W-1:0] buf_dat  [2];        // Two entries, ring order
    logic              buf_last [2];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        cnt;                 // Occupancy 0 to 2
    logic              push;
    logic              pop;

    assign s_rdy    = (cnt != 2'd2);
    assign out_vld  = (cnt != 2'd0);
    assign out_dat  = buf_dat[rd_ptr];      // Head entry
    assign out_last = buf_last[rd_ptr];
    assign push     = s_vld & s_rdy;
    assign pop      = out_vld & out_rdy;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            cnt    <= 2'd0;
        end else if (clr) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            cnt    <= 2'd0;
        end else begin
            wr_ptr <= wr_ptr ^ push;
            rd_ptr <= rd_ptr ^ pop;
            cnt    <= cnt + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            buf_dat[wr_ptr]  <= s_dat;
            buf_last[wr_ptr] <= s_last;
        end
    end

    // Full entries refuse the chunk, which must wait upstream unchanged
    a_no_overflow: assert property (@(posedge CLK) disable iff (!RST_N)
        (s_vld && !s_rdy && !clr) |=> (s_vld && $stable(s_dat) && $stable(s_last)));

endmodule

// File: piso_top.sv
`timescale 1ns/1ps

module piso_top #(
    parameter int  DATA_W = piso_pkg::DATA_W_DEF,
    localparam int BW_W   = piso_pkg::clog2_plus1(DATA_W)
) (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [1:0]        wb_adr,
    input  logic [31:0]       wb_dat_w,
    output logic [31:0]       wb_dat_r,
    output logic              wb_ack,
    input  logic [DATA_W-1:0] in_dat,
    input  logic              in_vld,
    input  logic              in_last,
    output logic              in_rdy,
    output logic [DATA_W-1:0] out_dat,
    output logic              out_vld,
    output logic              out_last,
    input  logic              out_rdy
);

    logic [BW_W-1:0]   inp_bw;
    logic [BW_W-1:0]   out_bw;
    logic              enable;
    logic              soft_clr;
    logic              busy;
    logic [DATA_W-1:0] s1_dat;              // Input slice to serializer
    logic              s1_vld;
    logic              s1_last;
    logic              s1_rdy;
    logic [DATA_W-1:0] s2_dat;              // Serializer to output slice
    logic              s2_vld;
    logic              s2_last;
    logic              s2_rdy;

    wb_cfg_regs #(.DATA_W(DATA_W)) regs_i (.*);

    stream_in_slice #(.DATA_W(DATA_W)) in_slice_i (
        .CLK, .RST_N, .clr(soft_clr), .enable, .in_dat, .in_vld, .in_last, .in_rdy,
        .s_dat(s1_dat), .s_vld(s1_vld), .s_last(s1_last), .s_rdy(s1_rdy));

    piso_flex #(.DATA_W(DATA_W)) piso_i (
        .CLK, .RST_N, .clr(soft_clr), .inp_bw, .out_bw,
        .in_dat(s1_dat), .in_vld(s1_vld), .in_last(s1_last), .in_rdy(s1_rdy),
        .out_dat(s2_dat), .out_vld(s2_vld), .out_last(s2_last), .out_rdy(s2_rdy), .busy);

    stream_out_slice #(.DATA_W(DATA_W)) out_slice_i (
        .CLK, .RST_N, .clr(soft_clr), .s_dat(s2_dat), .s_vld(s2_vld), .s_last(s2_last),
        .s_rdy(s2_rdy), .out_dat, .out_vld, .out_last, .out_rdy);

endmodule

// File: tb_piso_top.sv
`timescale 1ns/1ps

module tb_piso_top;
    import piso_pkg::*;

    localparam int DATA_W = 64;
    // Words per test times chunk ratio, four cycles a chunk, plus bus and reset time
    localparam int CYCLE_LIMIT = (8*4 + 8*1 + 16*8 + 6*2 + 4*4) * 4 + 500;

    logic              CLK, RST_N;
    logic              wb_cyc, wb_stb, wb_we, wb_ack;
    logic [1:0]        wb_adr;
    logic [31:0]       wb_dat_w, wb_dat_r;
    logic [DATA_W-1:0] in_dat, out_dat;
    logic              in_vld, in_last, in_rdy;
    logic              out_vld, out_last, out_rdy;

    logic [64:0]       exp_q [$];           // {last, chunk}, oldest first
    logic [63:0]       head_dat, cap_dat;
    logic              head_vld, head_last;
    logic              in_hs, out_hs, cap_last;
    logic              en_exp;              // Enable as last written
    logic [31:0]       rdy_seed = 32'ha455;
    logic [31:0]       dat_seed = 32'ha455;
    int                iw, ow, rdy_mode;    // rdy_mode 0 high, 1 random, 2 low
    int                err_cnt, err_mark, test_cnt, test_fail, pkt_sent, cycles;

    piso_top #(.DATA_W(DATA_W)) dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [63:0] width_mask(input int w);
        return (w >= 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
    endfunction

    // =========================================================
    // Scoreboard
    // =========================================================
    task automatic push_chunks(input logic [63:0] d, input logic l);
        logic [63:0] word;
        int          n;
        word = d & width_mask(iw);          // Bits above input width ignored
        n    = iw / ow;
        for (int i = 0; i < n; i++)         // Low chunk first
            exp_q.push_back({l && (i == n - 1), (word >> (i * ow)) & width_mask(ow)});
    endtask

    // Handshakes settle mid-cycle, acted on at the next edge
    always @(negedge CLK) begin
        in_hs    = in_vld & in_rdy;
        out_hs   = out_vld & out_rdy;
        cap_dat  = in_dat;
        cap_last = in_last;
    end

    always @(posedge CLK) begin
        if (out_hs && exp_q.size() > 0)
            void'(exp_q.pop_front());
        if (in_hs)
            push_chunks(cap_dat, cap_last);
        head_vld  <= (exp_q.size() > 0);
        head_dat  <= (exp_q.size() > 0) ? exp_q[0][63:0] : 64'd0;
        head_last <= (exp_q.size() > 0) ? exp_q[0][64] : 1'b0;
    end

    a_chunk_known: assert property (@(posedge CLK) disable iff (!RST_N)
        (out_vld && out_rdy) |-> head_vld)
        else begin
            err_cnt++;
            $display("Output chunk arrived with nothing expected at %0t", $time);
        end

    a_chunk_value: assert property (@(posedge CLK) disable iff (!RST_N)
        (out_vld && out_rdy && head_vld) |-> (out_dat == head_dat && out_last == head_last))
        else begin
            err_cnt++;
            $display("CHECK FAILED @%0t: chunk %h last %b, expected %h last %b", $time,
                     $sampled(out_dat), $sampled(out_last), $sampled(head_dat),
                     $sampled(head_last));
        end

    a_ack_pulse: assert property (@(posedge CLK) disable iff (!RST_N) wb_ack |=> !wb_ack)
        else begin
            err_cnt++;
            $display("Bus ack stayed high for more than one cycle at %0t", $time);
        end

    a_rdy_disabled: assert property (@(posedge CLK) disable iff (!RST_N) !en_exp |-> !in_rdy)
        else begin
            err_cnt++;
            $display("Input ready was high while the stream was disabled at %0t", $time);
        end

    // Run limit
    always @(posedge CLK) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Back-pressure on the output side
    initial begin
        forever begin
            @(posedge CLK);
            #1;
            rdy_seed = lcg_next(rdy_seed);
            out_rdy  = (rdy_mode == 0) ? 1'b1 : (rdy_mode == 1) ? rdy_seed[16] : 1'b0;
        end
    end

    // =========================================================
    // Bus and stream tasks
    // =========================================================
    task automatic wb_access(input logic we, input reg_addr_e adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(posedge CLK);
            #1;
        end while (!wb_ack);
        rdat   = wb_dat_r;                  // Read data valid in the ack cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (we && adr == REG_CTRL)
            en_exp = wdat[CTRL_EN_BIT];
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic set_widths(input int i, input int o);
        iw = i;
        ow = o;
        wb_write(REG_BW, (32'(o) << BW_OUT_LSB) | 32'(i));
    endtask

    task automatic send_word(input logic [63:0] d, input logic l);
        in_dat  = d;
        in_last = l;
        in_vld  = 1'b1;
        do @(negedge CLK); while (!in_rdy);
        @(posedge CLK);                     // Beat taken on this edge
        #1;
        in_vld = 1'b0;
        if (l)
            pkt_sent++;
    endtask

    task automatic next_rand(output logic [63:0] w);
        dat_seed = lcg_next(dat_seed);
        w[63:32] = dat_seed;
        dat_seed = lcg_next(dat_seed);
        w[31:0]  = dat_seed;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
        else begin
            err_cnt++;
            $display("CHECK FAILED @%0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic close_test(input string name);
        test_cnt++;
        if (err_cnt != err_mark)
            test_fail++;
        $display("test %0d %-26s %s", test_cnt, name, (err_cnt == err_mark) ? "ok" : "failed");
        err_mark = err_cnt;
    endtask

    // =========================================================
    // Test sequence
    // =========================================================
    initial begin
        logic [63:0] w;
        logic [31:0] rd;
        RST_N    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_w = 32'd0;
        in_dat   = '0;
        in_vld   = 1'b0;
        in_last  = 1'b0;
        out_rdy  = 1'b1;
        rdy_mode = 0;
        en_exp   = 1'b0;
        iw       = 64;                      // Reset widths
        ow       = 64;
        repeat (10) @(posedge CLK);
        #1;
        RST_N = 1'b1;

        wb_access(1'b0, REG_BW, 32'd0, rd);
        check_eq("BW after reset", rd, (32'd64 << BW_OUT_LSB) | 32'd64);
        set_widths(32, 16);
        wb_access(1'b0, REG_BW, 32'd0, rd);
        check_eq("BW", rd, (32'd16 << BW_OUT_LSB) | 32'd32);
        wb_write(REG_CTRL, 32'h3);          // Enable plus soft clear
        wb_access(1'b0, REG_CTRL, 32'd0, rd);
        check_eq("CTRL", rd, 32'h1);
        close_test("register access");

        set_widths(64, 16);
        for (int i = 0; i < 8; i++) begin
            next_rand(w);
            send_word(w, i == 7);
        end
        wait_drain();
        close_test("split 64 to 16");

        set_widths(32, 32);                 // Ratio one
        for (int i = 0; i < 8; i++) begin
            next_rand(w);
            send_word(w, i == 7);
        end
        wait_drain();
        close_test("ratio one 32 to 32");

        set_widths(64, 8);
        rdy_mode = 1;
        for (int i = 0; i < 16; i++) begin
            next_rand(w);
            send_word(w, i == 15);
        end
        wait_drain();
        rdy_mode = 0;
        close_test("random stalls 64 to 8");

        set_widths(64, 32);
        for (int p = 0; p < 3; p++) begin   // Packets of 1, 2, 3 words
            for (int j = 0; j <= p; j++) begin
                next_rand(w);
                send_word(w, j == p);
            end
        end
        wait_drain();
        wb_access(1'b0, REG_PKTS, 32'd0, rd);
        check_eq("PKTS", rd, 32'(pkt_sent));
        close_test("packet marking");

        wb_write(REG_CTRL, 32'h0);
        set_widths(64, 16);
        rdy_mode = 2;                       // Output blocked, words stay held
        next_rand(w);
        in_dat  = w;
        in_last = 1'b0;
        in_vld  = 1'b1;                     // Offered, waits while disabled
        repeat (6) begin
            @(posedge CLK);
            #1;
        end
        wb_write(REG_CTRL, 32'h1);
        send_word(w, 1'b0);                 // Same word, taken once enabled
        next_rand(w);
        send_word(w, 1'b0);
        wb_access(1'b0, REG_STATUS, 32'd0, rd);
        check_eq("STATUS with held word", rd, 32'h1);
        wb_write(REG_CTRL, 32'h3);
        exp_q.delete();                     // Held chunks are dropped by the clear
        wb_access(1'b0, REG_STATUS, 32'd0, rd);
        check_eq("STATUS after soft clear", rd, 32'h0);
        rdy_mode = 0;
        for (int i = 0; i < 2; i++) begin
            next_rand(w);
            send_word(w, i == 1);
        end
        wait_drain();
        wb_access(1'b0, REG_PKTS, 32'd0, rd);
        check_eq("PKTS after clear", rd, 32'(pkt_sent));
        close_test("disable and soft clear");

        $display("summary: %0d tests, %0d failed, %0d check errors",
                 test_cnt, test_fail, err_cnt);
        if (err_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: vlog.f
piso_pkg.sv
wb_cfg_regs.sv
stream_in_slice.sv
piso_flex.sv
stream_out_slice.sv
piso_top.sv
tb_piso_top.sv

// File: Makefile
TOP = tb_piso_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean
